/* common/armAddrPkg.sv */
`default_nettype none

package armAddrPkg;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int InstrWidth   = 32;
  localparam int PhysWidth    = 32;
  localparam int PhysIdxWidth = 5;
  localparam int ArchWidth    = 4;
  localparam int ModeWidth    = 5;
  localparam int FwdWidth     = 2;
  localparam int ExcWidth     = 7;

  // One-hot physical register select, bit 31 stays unused
  typedef logic [PhysWidth-1:0] physRegT;
  // Architectural register number straight from the instruction
  typedef logic [ArchWidth-1:0] archRegT;
  // CPSR mode field
  typedef logic [ModeWidth-1:0] modeT;

  // CPSR[4:0] encodings
  localparam modeT ModeUsr = 5'b10000;
  localparam modeT ModeFiq = 5'b10001;
  localparam modeT ModeIrq = 5'b10010;
  localparam modeT ModeSvc = 5'b10011;
  localparam modeT ModeAbt = 5'b10111;
  localparam modeT ModeUnd = 5'b11011;
  localparam modeT ModeSys = 5'b11111;

  // Named architectural registers
  localparam archRegT RegSp = 4'd13;
  localparam archRegT RegLr = 4'd14;
  localparam archRegT RegPc = 4'd15;

  // ====================================================================
  // Physical bank base bits
  // ====================================================================
  // User R0..R15 on bits 0..15
  localparam logic [PhysIdxWidth-1:0] IdxUser = 5'd0;
  // FIQ R8..R14 on bits 16..22
  localparam logic [PhysIdxWidth-1:0] IdxFiq  = 5'd16;
  // Banked R13/R14 pairs for the other privileged modes
  localparam logic [PhysIdxWidth-1:0] IdxIrq  = 5'd23;
  localparam logic [PhysIdxWidth-1:0] IdxSvc  = 5'd25;
  localparam logic [PhysIdxWidth-1:0] IdxAbt  = 5'd27;
  localparam logic [PhysIdxWidth-1:0] IdxUnd  = 5'd29;

  // Exception flag bits, MSB is highest priority
  localparam int ExcReset = 6;
  localparam int ExcDabt  = 5;
  localparam int ExcFiq   = 4;
  localparam int ExcIrq   = 3;
  localparam int ExcPabt  = 2;
  localparam int ExcUnd   = 1;
  localparam int ExcSwi   = 0;

  // Vector table
  localparam logic [InstrWidth-1:0] VecReset = 32'h0000_0000;
  localparam logic [InstrWidth-1:0] VecUndef = 32'h0000_0004;
  localparam logic [InstrWidth-1:0] VecSwi   = 32'h0000_0008;
  localparam logic [InstrWidth-1:0] VecPabt  = 32'h0000_000C;
  localparam logic [InstrWidth-1:0] VecDabt  = 32'h0000_0010;
  localparam logic [InstrWidth-1:0] VecIrq   = 32'h0000_0018;
  localparam logic [InstrWidth-1:0] VecFiq   = 32'h0000_001C;

  // Forwarding mux selects for the ALU operands
  localparam logic [FwdWidth-1:0] FwdNone = 2'b00;
  localparam logic [FwdWidth-1:0] FwdWb   = 2'b01;
  localparam logic [FwdWidth-1:0] FwdMem  = 2'b10;

endpackage

`default_nettype wire

/* design/stageReg.sv */
`timescale 1ns/10ps
`default_nettype none

// Pipeline register, payload chosen per instance
module stageReg #(
  parameter type payloadT = logic [31:0]
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    en,
  input  logic    clr,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (clr) begin
      // Bubble, no register selected
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* addresspath/bankedAddrDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module bankedAddrDecode (
  input  armAddrPkg::archRegT arch,
  input  armAddrPkg::modeT    mode,
  output armAddrPkg::physRegT phys
);

  import armAddrPkg::*;

  logic [PhysIdxWidth-1:0] idx;
  logic [PhysIdxWidth-1:0] archIdx;
  // Offset into the FIQ bank, R8 lands on 0
  logic [PhysIdxWidth-1:0] fiqOff;
  // Offset into a two-entry bank, R13 lands on 0
  logic [PhysIdxWidth-1:0] spLrOff;
  logic                    isHigh;
  logic                    isSpLr;

  assign archIdx = {1'b0, arch};
  assign fiqOff  = archIdx - 5'd8;
  assign spLrOff = archIdx - {1'b0, RegSp};

  // R8..R12 are only banked for FIQ
  assign isHigh = (arch >= 4'd8) && (arch <= 4'd12);
  assign isSpLr = (arch == RegSp) || (arch == RegLr);

  always_comb begin
    // User bank by default, covers R0..R7, PC, usr and sys
    idx = IdxUser + archIdx;
    if (isHigh && (mode == ModeFiq)) begin
      idx = IdxFiq + fiqOff;
    end else if (isSpLr) begin
      case (mode)
        ModeFiq: idx = IdxFiq + fiqOff;
        ModeIrq: idx = IdxIrq + spLrOff;
        ModeSvc: idx = IdxSvc + spLrOff;
        ModeAbt: idx = IdxAbt + spLrOff;
        ModeUnd: idx = IdxUnd + spLrOff;
        // Usr, sys and unknown encodings
        default: idx = IdxUser + archIdx;
      endcase
    end
  end

  // One-hot expansion
  assign phys = physRegT'(1) << idx;

endmodule

`default_nettype wire

/* addresspath/addressPath.sv */
`timescale 1ns/10ps
`default_nettype none

module addressPath (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic [armAddrPkg::InstrWidth-1:0]   instrD,
  input  logic [armAddrPkg::InstrWidth-1:0]   instrE,
  input  logic                                multSelectD,
  input  logic                                writeMultLoE,
  input  logic                                swiE,
  input  logic                                undefE,
  input  logic [1:0]                          regSrcD,
  input  armAddrPkg::modeT                    cpsrModeW,
  input  logic                                stallE,
  input  logic                                stallM,
  input  logic                                stallW,
  input  logic                                flushE,
  input  logic                                flushW,
  output armAddrPkg::physRegT                 ra1D,
  output armAddrPkg::physRegT                 ra2D,
  output armAddrPkg::physRegT                 wa3W,
  output logic                                match1EM,
  output logic                                match1EW,
  output logic                                match2EM,
  output logic                                match2EW,
  output logic                                match1DE,
  output logic                                match2DE
);

  import armAddrPkg::*;

  archRegT ra1ArchD;
  archRegT ra2ArchD;
  archRegT destArchD;
  modeT    modeD;
  modeT    modeE;
  physRegT wa3D;
  physRegT ra1E;
  physRegT ra2E;
  physRegT wa3RawE;
  physRegT rdLoE;
  physRegT wa3E;
  physRegT wa3M;

  // Equal and something actually selected
  function automatic logic selMatch(input physRegT a, input physRegT b);
    selMatch = (a == b) && (a != '0);
  endfunction

  // ====================================================================
  // Decode
  // ====================================================================
  // Rm for multiply, else PC or Rn
  assign ra1ArchD = multSelectD ? instrD[3:0] :
                    regSrcD[0]  ? RegPc       : instrD[19:16];
  // Rs for multiply, else Rd (stores) or Rm
  assign ra2ArchD = multSelectD ? instrD[11:8]  :
                    regSrcD[1]  ? instrD[15:12] : instrD[3:0];
  // Multiply writes Rd at [19:16]
  assign destArchD = multSelectD ? instrD[19:16] : instrD[15:12];

  // SWI and undefined switch banks ahead of the CPSR write
  assign modeD = swiE   ? ModeSvc :
                 undefE ? ModeUnd : cpsrModeW;

  bankedAddrDecode ra1Dec  (.arch(ra1ArchD),  .mode(modeD), .phys(ra1D));
  bankedAddrDecode ra2Dec  (.arch(ra2ArchD),  .mode(modeD), .phys(ra2D));
  bankedAddrDecode destDec (.arch(destArchD), .mode(modeD), .phys(wa3D));

  // ====================================================================
  // Execute
  // ====================================================================
  stageReg #(.payloadT(physRegT)) ra1Reg (
    .clk(clk), .arstN(arstN), .en(~stallE), .clr(flushE), .d(ra1D), .q(ra1E)
  );
  stageReg #(.payloadT(physRegT)) ra2Reg (
    .clk(clk), .arstN(arstN), .en(~stallE), .clr(flushE), .d(ra2D), .q(ra2E)
  );
  stageReg #(.payloadT(physRegT)) wa3EReg (
    .clk(clk), .arstN(arstN), .en(~stallE), .clr(flushE), .d(wa3D), .q(wa3RawE)
  );
  // Mode seen by this instruction, for the RdLo bank
  stageReg #(.payloadT(modeT)) modeEReg (
    .clk(clk), .arstN(arstN), .en(~stallE), .clr(flushE), .d(modeD), .q(modeE)
  );

  // Long multiply second write goes to RdLo
  bankedAddrDecode rdLoDec (.arch(instrE[15:12]), .mode(modeE), .phys(rdLoE));
  assign wa3E = writeMultLoE ? rdLoE : wa3RawE;

  // ====================================================================
  // Memory and writeback
  // ====================================================================
  // No flush source for M
  stageReg #(.payloadT(physRegT)) wa3MReg (
    .clk(clk), .arstN(arstN), .en(~stallM), .clr(1'b0), .d(wa3E), .q(wa3M)
  );
  stageReg #(.payloadT(physRegT)) wa3WReg (
    .clk(clk), .arstN(arstN), .en(~stallW), .clr(flushW), .d(wa3M), .q(wa3W)
  );

  // Forwarding compares against E operands
  assign match1EM = selMatch(wa3M, ra1E);
  assign match1EW = selMatch(wa3W, ra1E);
  assign match2EM = selMatch(wa3M, ra2E);
  assign match2EW = selMatch(wa3W, ra2E);
  // Load-use compares, decode sources against E destination
  assign match1DE = selMatch(wa3E, ra1D);
  assign match2DE = selMatch(wa3E, ra2D);

endmodule

`default_nettype wire

/* design/exceptionVector.sv */
`timescale 1ns/10ps
`default_nettype none

module exceptionVector (
  input  logic [armAddrPkg::ExcWidth-1:0]   excW,
  output logic [armAddrPkg::InstrWidth-1:0] vectorPcNextF,
  output logic                              exceptionVectorSelectW
);

  import armAddrPkg::*;

  // Fixed ARM priority, reset first and SWI last
  always_comb begin
    if (excW[ExcReset]) begin
      vectorPcNextF = VecReset;
    end else if (excW[ExcDabt]) begin
      vectorPcNextF = VecDabt;
    end else if (excW[ExcFiq]) begin
      vectorPcNextF = VecFiq;
    end else if (excW[ExcIrq]) begin
      vectorPcNextF = VecIrq;
    end else if (excW[ExcPabt]) begin
      vectorPcNextF = VecPabt;
    end else if (excW[ExcUnd]) begin
      vectorPcNextF = VecUndef;
    end else if (excW[ExcSwi]) begin
      vectorPcNextF = VecSwi;
    end else begin
      // Unused when select is low
      vectorPcNextF = VecReset;
    end
  end

  // Any pending exception steers fetch
  assign exceptionVectorSelectW = |excW;

endmodule

`default_nettype wire

/* design/hazardForward.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardForward (
  input  logic                              match1EM,
  input  logic                              match1EW,
  input  logic                              match2EM,
  input  logic                              match2EW,
  input  logic                              match1DE,
  input  logic                              match2DE,
  input  logic                              regWriteM,
  input  logic                              regWriteW,
  input  logic                              memToRegE,
  input  logic                              stallMem,
  output logic [armAddrPkg::FwdWidth-1:0]   forwardAE,
  output logic [armAddrPkg::FwdWidth-1:0]   forwardBE,
  output logic                              stallF,
  output logic                              stallD,
  output logic                              stallE,
  output logic                              stallM,
  output logic                              stallW,
  output logic                              flushE,
  output logic                              flushW
);

  import armAddrPkg::*;

  logic loadUse;

  // Youngest result wins
  function automatic logic [FwdWidth-1:0] fwdSel(input logic matchM, input logic matchW);
    if (matchM) begin
      fwdSel = FwdMem;
    end else if (matchW) begin
      fwdSel = FwdWb;
    end else begin
      fwdSel = FwdNone;
    end
  endfunction

  // Each match only counts when that stage writes a register
  assign forwardAE = fwdSel(match1EM && regWriteM, match1EW && regWriteW);
  assign forwardBE = fwdSel(match2EM && regWriteM, match2EW && regWriteW);

  // ====================================================================
  // Stalls and flushes
  // ====================================================================
  // Load in E feeding an operand in D
  assign loadUse = memToRegE && (match1DE || match2DE);

  assign stallF = loadUse || stallMem;
  assign stallD = loadUse || stallMem;

  // Memory wait freezes the back end as one
  assign stallE = stallMem;
  assign stallM = stallMem;
  assign stallW = stallMem;

  // Bubble into E only while the back end moves
  assign flushE = loadUse && !stallMem;

  // Hook for a writeback kill, never raised yet
  assign flushW = 1'b0;

endmodule

`default_nettype wire

/* design/addressUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module addressUnit (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic [armAddrPkg::InstrWidth-1:0]   instrD,
  input  logic [armAddrPkg::InstrWidth-1:0]   instrE,
  input  logic                                multSelectD,
  input  logic                                writeMultLoE,
  input  logic                                swiE,
  input  logic                                undefE,
  input  logic [1:0]                          regSrcD,
  input  armAddrPkg::modeT                    cpsrModeW,
  input  logic                                regWriteM,
  input  logic                                regWriteW,
  input  logic                                memToRegE,
  input  logic                                stallMem,
  input  logic [armAddrPkg::ExcWidth-1:0]     excW,
  output armAddrPkg::physRegT                 ra1D,
  output armAddrPkg::physRegT                 ra2D,
  output armAddrPkg::physRegT                 wa3W,
  output logic [armAddrPkg::FwdWidth-1:0]     forwardAE,
  output logic [armAddrPkg::FwdWidth-1:0]     forwardBE,
  output logic                                stallF,
  output logic                                stallD,
  output logic [armAddrPkg::InstrWidth-1:0]   vectorPcNextF,
  output logic                                exceptionVectorSelectW
);

  // Compare results towards the hazard unit
  logic match1EM, match1EW, match2EM, match2EW, match1DE, match2DE;
  // Stage control back into the address pipeline
  logic stallE, stallM, stallW, flushE, flushW;

  addressPath addrPath (
    .clk(clk), .arstN(arstN),
    .instrD(instrD), .instrE(instrE),
    .multSelectD(multSelectD), .writeMultLoE(writeMultLoE),
    .swiE(swiE), .undefE(undefE),
    .regSrcD(regSrcD), .cpsrModeW(cpsrModeW),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushW(flushW),
    .ra1D(ra1D), .ra2D(ra2D), .wa3W(wa3W),
    .match1EM(match1EM), .match1EW(match1EW),
    .match2EM(match2EM), .match2EW(match2EW),
    .match1DE(match1DE), .match2DE(match2DE)
  );

  hazardForward hazard (
    .match1EM(match1EM), .match1EW(match1EW),
    .match2EM(match2EM), .match2EW(match2EW),
    .match1DE(match1DE), .match2DE(match2DE),
    .regWriteM(regWriteM), .regWriteW(regWriteW),
    .memToRegE(memToRegE), .stallMem(stallMem),
    .forwardAE(forwardAE), .forwardBE(forwardBE),
    .stallF(stallF), .stallD(stallD),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushW(flushW)
  );

  // Sits next to fetch
  exceptionVector excVec (
    .excW(excW),
    .vectorPcNextF(vectorPcNextF),
    .exceptionVectorSelectW(exceptionVectorSelectW)
  );

endmodule

`default_nettype wire

/* verif/addressUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module addressUnitTb;

  import armAddrPkg::*;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 3;
  localparam int NumDirected = 31;
  localparam int NumRandom   = 40;
  localparam int NumRows     = NumDirected + NumRandom;
  // Reset plus one cycle per row, with some slack
  localparam int WatchdogNs  = (NumRows + ResetCycles + 8) * ClkPeriod;

  // One stimulus row with its expected responses
  typedef struct packed {
    logic [31:0] instr;
    logic [1:0]  regSrc;
    modeT        mode;
    logic        mult;
    logic        swi;
    logic        undef;
    logic [3:0]  loArch;
    logic        wLo;
    logic        regWM;
    logic        regWW;
    logic        memToReg;
    logic        stallMem;
    logic [6:0]  exc;
    int          ra1Bit;
    logic [1:0]  fwdA;
    logic [1:0]  fwdB;
    logic        stallFD;
    logic [31:0] vec;
  } rowT;

  logic        clk;
  logic        arstN;
  logic [31:0] instrD;
  logic [31:0] instrE;
  logic        multSelectD;
  logic        writeMultLoE;
  logic        swiE;
  logic        undefE;
  logic [1:0]  regSrcD;
  modeT        cpsrModeW;
  logic        regWriteM;
  logic        regWriteW;
  logic        memToRegE;
  logic        stallMem;
  logic [6:0]  excW;
  physRegT     ra1D;
  physRegT     ra2D;
  physRegT     wa3W;
  logic [1:0]  forwardAE;
  logic [1:0]  forwardBE;
  logic        stallF;
  logic        stallD;
  logic [31:0] vectorPcNextF;
  logic        exceptionVectorSelectW;

  rowT     rows [NumRows];
  int      nRows;
  integer  seed;
  rowT     r;
  int      i;
  modeT    effMode;
  physRegT expRa2;
  physRegT expDest;
  physRegT expWa3E;
  // Reference pipeline state
  physRegT mDestE;
  modeT    mModeE;
  physRegT mWa3M;
  physRegT mWa3W;

  addressUnit UUT (
    .clk(clk), .arstN(arstN),
    .instrD(instrD), .instrE(instrE),
    .multSelectD(multSelectD), .writeMultLoE(writeMultLoE),
    .swiE(swiE), .undefE(undefE),
    .regSrcD(regSrcD), .cpsrModeW(cpsrModeW),
    .regWriteM(regWriteM), .regWriteW(regWriteW),
    .memToRegE(memToRegE), .stallMem(stallMem), .excW(excW),
    .ra1D(ra1D), .ra2D(ra2D), .wa3W(wa3W),
    .forwardAE(forwardAE), .forwardBE(forwardBE),
    .stallF(stallF), .stallD(stallD),
    .vectorPcNextF(vectorPcNextF),
    .exceptionVectorSelectW(exceptionVectorSelectW)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ====================================================================
  // Reference rules
  // ====================================================================
  // Rn at [19:16], Rd at [15:12], Rs at [11:8], Rm at [3:0]
  function automatic logic [31:0] mkInstr(input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [3:0] rs, input logic [3:0] rm);
    return {12'h000, rn, rd, rs, 4'h0, rm};
  endfunction

  function automatic logic [3:0] ra1Arch(input logic [31:0] ins, input logic mult,
                                         input logic [1:0] src);
    if (mult) begin
      return ins[3:0];
    end else if (src[0]) begin
      return 4'd15;
    end
    return ins[19:16];
  endfunction

  function automatic logic [3:0] ra2Arch(input logic [31:0] ins, input logic mult,
                                         input logic [1:0] src);
    if (mult) begin
      return ins[11:8];
    end else if (src[1]) begin
      return ins[15:12];
    end
    return ins[3:0];
  endfunction

  function automatic logic [3:0] destArch(input logic [31:0] ins, input logic mult);
    return mult ? ins[19:16] : ins[15:12];
  endfunction

  // Physical bit of a register in a given mode
  function automatic int bankBit(input logic [3:0] a, input modeT m);
    int b;
    b = int'(a);
    if (m == ModeFiq && a >= 4'd8 && a <= 4'd14) begin
      b = 16 + int'(a) - 8;
    end else if (a == 4'd13 || a == 4'd14) begin
      case (m)
        ModeIrq: b = 23 + int'(a) - 13;
        ModeSvc: b = 25 + int'(a) - 13;
        ModeAbt: b = 27 + int'(a) - 13;
        ModeUnd: b = 29 + int'(a) - 13;
        default: b = int'(a);
      endcase
    end
    return b;
  endfunction

  function automatic physRegT oneHot(input int b);
    return physRegT'(1) << b;
  endfunction

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic addRow(input logic [31:0] instr, input logic [1:0] regSrc, input modeT mode,
                        input logic mult, input logic swi, input logic undef,
                        input logic [3:0] loArch, input logic wLo, input logic regWM,
                        input logic regWW, input logic memToReg, input logic stallW,
                        input logic [6:0] exc, input int ra1Bit, input logic [1:0] fwdA,
                        input logic [1:0] fwdB, input logic stallFD, input logic [31:0] vec);
    rows[nRows] = '{instr, regSrc, mode, mult, swi, undef, loArch, wLo, regWM, regWW,
                    memToReg, stallW, exc, ra1Bit, fwdA, fwdB, stallFD, vec};
    nRows++;
  endtask

  // ====================================================================
  // Stimulus table
  // ====================================================================
  task automatic buildTable;
    logic [31:0] instr;
    logic [31:0] ctl;
    logic [3:0]  arch;
    int          k;
    nRows = 0;
    // instr, src, mode, mul swi und, lo wLo, rwM rwW ld wait, exc, ra1, fwdA fwdB, stall, vec
    // Bank decode of Rn, one exception flag per row
    addRow(mkInstr(13, 1, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000001, 13, FwdNone, FwdNone, 0, VecSwi);
    addRow(mkInstr(13, 3, 0, 4), 2'b00, ModeFiq, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000010, 21, FwdNone, FwdNone, 0, VecUndef);
    addRow(mkInstr(13, 5, 0, 6), 2'b00, ModeIrq, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000100, 23, FwdNone, FwdNone, 0, VecPabt);
    addRow(mkInstr(13, 7, 0, 0), 2'b00, ModeSvc, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0001000, 25, FwdNone, FwdNone, 0, VecIrq);
    addRow(mkInstr(9, 8, 0, 10), 2'b00, ModeFiq, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0010000, 17, FwdNone, FwdNone, 0, VecFiq);
    addRow(mkInstr(9, 11, 0, 12), 2'b00, ModeIrq, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0100000, 9, FwdNone, FwdNone, 0, VecDabt);
    // PC select, then several flags at once
    addRow(mkInstr(3, 2, 0, 1), 2'b01, ModeFiq, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b1000000, 15, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(3, 9, 0, 1), 2'b11, ModeSvc, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0011010, 15, FwdNone, FwdNone, 0, VecFiq);
    // SWI and undefined override the CPSR mode
    addRow(mkInstr(14, 13, 0, 1), 2'b00, ModeUsr, 0, 1, 0, 0, 0, 0, 0, 0, 0,
           7'b0001101, 26, FwdNone, FwdNone, 0, VecIrq);
    addRow(mkInstr(13, 14, 0, 1), 2'b00, ModeFiq, 0, 0, 1, 0, 0, 0, 0, 0, 0,
           7'b1111111, 29, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(14, 2, 0, 3), 2'b00, ModeAbt, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 28, FwdNone, FwdNone, 0, VecReset);
    // Multiply operands, then RdLo redirect in E
    addRow(mkInstr(2, 3, 4, 5), 2'b00, ModeUsr, 1, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 5, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(1, 7, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 6, 1, 0, 0, 0, 0,
           7'b0000000, 1, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(0, 0, 0, 0), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 0, FwdNone, FwdNone, 0, VecReset);
    // Forwarding from M and W
    addRow(mkInstr(1, 8, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 1, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(8, 9, 0, 3), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 8, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(4, 10, 0, 9), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 1, 0, 0, 0,
           7'b0000000, 4, FwdMem, FwdNone, 0, VecReset);
    addRow(mkInstr(5, 11, 0, 12), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 1, 1, 0, 0,
           7'b0000000, 5, FwdNone, FwdMem, 0, VecReset);
    addRow(mkInstr(10, 13, 0, 1), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 10, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(11, 11, 0, 11), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 1, 1, 0, 0,
           7'b0000000, 11, FwdWb, FwdNone, 0, VecReset);
    // W match without regWriteW
    addRow(mkInstr(2, 12, 0, 3), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 1, 0, 0, 0,
           7'b0000000, 2, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(4, 12, 0, 5), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 4, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(12, 1, 0, 12), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 12, FwdNone, FwdNone, 0, VecReset);
    // M and W both match, M wins
    addRow(mkInstr(3, 2, 0, 3), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 1, 1, 0, 0,
           7'b0000000, 3, FwdMem, FwdMem, 0, VecReset);
    // Load into R9 then a use of R9
    addRow(mkInstr(1, 9, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 1, FwdNone, FwdNone, 0, VecReset);
    addRow(mkInstr(9, 3, 0, 4), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 1, 0,
           7'b0000000, 9, FwdNone, FwdNone, 1, VecReset);
    addRow(mkInstr(9, 3, 0, 4), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 1, 0,
           7'b0000000, 9, FwdNone, FwdNone, 0, VecReset);
    // Memory wait for three cycles
    addRow(mkInstr(1, 5, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 1,
           7'b0000000, 1, FwdNone, FwdNone, 1, VecReset);
    addRow(mkInstr(1, 5, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 1,
           7'b0000000, 1, FwdNone, FwdNone, 1, VecReset);
    addRow(mkInstr(1, 5, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 1,
           7'b0000000, 1, FwdNone, FwdNone, 1, VecReset);
    addRow(mkInstr(1, 5, 0, 2), 2'b00, ModeUsr, 0, 0, 0, 0, 0, 0, 0, 0, 0,
           7'b0000000, 1, FwdNone, FwdNone, 0, VecReset);
    // Random user mode filler, no writes and no loads
    for (k = 0; k < NumRandom; k++) begin
      instr = $random(seed);
      ctl   = $random(seed);
      // User bank puts every register on its own number
      arch  = ra1Arch(instr, ctl[0], ctl[2:1]);
      addRow(instr, ctl[2:1], ModeUsr, ctl[0], 0, 0, 0, 0, 0, 0, 0, 0,
             7'b0000000, int'(arch), FwdNone, FwdNone, 0, VecReset);
    end
  endtask

  task automatic driveRow(input rowT row);
    instrD       = row.instr;
    instrE       = {16'h0000, row.loArch, 12'h000};
    multSelectD  = row.mult;
    writeMultLoE = row.wLo;
    swiE         = row.swi;
    undefE       = row.undef;
    regSrcD      = row.regSrc;
    cpsrModeW    = row.mode;
    regWriteM    = row.regWM;
    regWriteW    = row.regWW;
    memToRegE    = row.memToReg;
    stallMem     = row.stallMem;
    excW         = row.exc;
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    clk          = 1'b0;
    arstN        = 1'b0;
    instrD       = '0;
    instrE       = '0;
    multSelectD  = 1'b0;
    writeMultLoE = 1'b0;
    swiE         = 1'b0;
    undefE       = 1'b0;
    regSrcD      = 2'b00;
    cpsrModeW    = ModeUsr;
    regWriteM    = 1'b0;
    regWriteW    = 1'b0;
    memToRegE    = 1'b0;
    stallMem     = 1'b0;
    excW         = '0;
    seed         = 32'hea7b_444a;
    mDestE       = '0;
    mModeE       = '0;
    mWa3M        = '0;
    mWa3W        = '0;
    buildTable();
    if (nRows != NumRows) begin
      $display("Simulation failed");
      $fatal(1, "Stimulus table holds %0d rows instead of %0d", nRows, NumRows);
    end
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    for (i = 0; i < NumRows; i++) begin
      r = rows[i];
      driveRow(r);
      effMode = r.swi ? ModeSvc : (r.undef ? ModeUnd : r.mode);
      expRa2  = oneHot(bankBit(ra2Arch(r.instr, r.mult, r.regSrc), effMode));
      expDest = oneHot(bankBit(destArch(r.instr, r.mult), effMode));
      // RdLo uses the mode latched with the instruction in E
      expWa3E = r.wLo ? oneHot(bankBit(r.loArch, mModeE)) : mDestE;
      #1;
      checkEq("ra1D", ra1D, oneHot(r.ra1Bit));
      checkEq("ra2D", ra2D, expRa2);
      checkEq("wa3W", wa3W, mWa3W);
      checkEq("forwardAE", 32'(forwardAE), 32'(r.fwdA));
      checkEq("forwardBE", 32'(forwardBE), 32'(r.fwdB));
      checkEq("stallF", 32'(stallF), 32'(r.stallFD));
      checkEq("stallD", 32'(stallD), 32'(r.stallFD));
      checkEq("exceptionVectorSelectW", 32'(exceptionVectorSelectW), 32'(|r.exc));
      if (r.exc != '0) begin
        checkEq("vectorPcNextF", vectorPcNextF, r.vec);
      end
      // Model of the coming edge, memory wait freezes E, M and W
      if (!r.stallMem) begin
        mWa3W = mWa3M;
        mWa3M = expWa3E;
        if (r.stallFD) begin
          // Load-use bubble into E
          mDestE = '0;
          mModeE = '0;
        end else begin
          mDestE = expDest;
          mModeE = effMode;
        end
      end
      @(negedge clk);
    end
    $display("Simulation passed");
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired before all stimulus rows were applied");
  end

endmodule

`default_nettype wire

/* flist.f */
common/armAddrPkg.sv
design/stageReg.sv
addresspath/bankedAddrDecode.sv
addresspath/addressPath.sv
design/exceptionVector.sv
design/hazardForward.sv
design/addressUnit.sv
verif/addressUnitTb.sv

/* Makefile */
# Verilator flow for the address unit
TOP = addressUnitTb

.PHONY: all run lint clean

all: run

# Build and run, a $fatal in the testbench gives a nonzero exit status
run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module addressUnit -f flist.f

clean:
	rm -rf obj_dir
